// File: csr_pkg.sv
package csr_pkg;

    localparam int CSR_W      = 32;
    localparam int CSR_ADDR_W = 14;

    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044,
        CSR_LLBCTL = 14'h060
    } csr_addr_e;

    typedef enum logic [5:0] {
        ECODE_INT  = 6'h00,
        ECODE_PIL  = 6'h01,
        ECODE_PIS  = 6'h02,
        ECODE_ADE  = 6'h08,
        ECODE_ALE  = 6'h09,
        ECODE_SYS  = 6'h0b,
        ECODE_BRK  = 6'h0c,
        ECODE_INE  = 6'h0d,
        ECODE_TLBR = 6'h3f
    } ecode_e;

    // CRMD fields
    localparam int CRMD_PLV_LO  = 0;
    localparam int CRMD_IE      = 2;
    localparam int CRMD_DA      = 3;
    localparam int CRMD_PG      = 4;
    localparam int CRMD_DATF_LO = 5;
    localparam int CRMD_DATM_LO = 7;

    // ESTAT fields
    localparam int ESTAT_IS_SOFT_LO = 0;
    localparam int ESTAT_IS_HARD_LO = 2;
    localparam int ESTAT_IS_TI      = 11;
    localparam int ESTAT_ECODE_LO   = 16;
    localparam int ESTAT_ESUB_LO    = 22;

    localparam int TCFG_EN         = 0;
    localparam int TCFG_PERIODIC   = 1;
    localparam int TCFG_INITVAL_LO = 2;

    localparam int LLBCTL_ROLLB = 0;
    localparam int LLBCTL_WCLLB = 1;
    localparam int LLBCTL_KLO   = 2;

    localparam int          IS_W         = 13;
    localparam logic [12:0] LIE_MASK     = 13'h1bff;
    localparam int          EENTRY_VA_LO = 6;

    // Added to INITVAL so that a zero setting still fires
    localparam int TIMER_BIAS        = 1000;
    localparam int WRITE_IDLE_CYCLES = 3;

endpackage

// File: csr_write_stage.sv
module csr_write_stage import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  aresetn,
    input  logic                  d_idle,
    input  logic                  wen_in,
    input  logic [CSR_ADDR_W-1:0] addr_in,
    input  logic [CSR_W-1:0]      wdata_in,
    input  logic                  flush_to_priv_wr_csr,
    output logic                  wr_en,
    output logic [CSR_ADDR_W-1:0] wr_addr,
    output logic [CSR_W-1:0]      wr_data,
    output logic                  wen_csr
);

    logic                                 pending;
    logic [$clog2(WRITE_IDLE_CYCLES)-1:0] idle_cnt;
    logic                                 step;

    assign step    = pending && d_idle;
    assign wr_en   = step && (idle_cnt == ($bits(idle_cnt))'(WRITE_IDLE_CYCLES - 1));
    assign wen_csr = step && (idle_cnt == '0);

    always_ff @(posedge clk) begin
        if (!aresetn || flush_to_priv_wr_csr) begin
            pending  <= 1'b0;
            idle_cnt <= '0;
        end else if (wen_in) begin
            pending  <= 1'b1;
            idle_cnt <= '0;
        end else if (wr_en) begin
            pending  <= 1'b0;
            idle_cnt <= '0;
        end else if (step) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    // Pending write address and data
    always_ff @(posedge clk) begin
        if (wen_in) begin
            wr_addr <= addr_in;
            wr_data <= wdata_in;
        end
    end

endmodule

// File: csr_trap_regs.sv
module csr_trap_regs import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  aresetn,
    input  logic                  wr_en,
    input  logic [CSR_ADDR_W-1:0] wr_addr,
    input  logic [CSR_W-1:0]      wr_data,
    input  logic                  exception,
    input  logic                  ertn,
    input  logic                  tlb_exception,
    input  logic [6:0]            expcode_in,
    input  logic                  wen_expcode,
    input  logic [CSR_W-1:0]      era_in,
    input  logic                  wen_era,
    input  logic [CSR_W-1:0]      badv_in,
    input  logic                  wen_badv,
    input  logic [7:0]            hardware_interrupt,
    input  logic                  ti_pending,
    output logic [CSR_W-1:0]      crmd,
    output logic [CSR_W-1:0]      prmd,
    output logic [CSR_W-1:0]      ecfg,
    output logic [CSR_W-1:0]      estat,
    output logic [CSR_W-1:0]      era,
    output logic [CSR_W-1:0]      badv,
    output logic [CSR_W-1:0]      eentry,
    output logic                  cpu_interrupt,
    output logic                  idle_over
);

    logic                      exc_d;
    logic                      exc_pulse;
    logic [1:0]                crmd_plv;
    logic                      crmd_ie;
    logic                      crmd_da;
    logic                      crmd_pg;
    logic [1:0]                crmd_datf;
    logic [1:0]                crmd_datm;
    logic [1:0]                prmd_pplv;
    logic                      prmd_pie;
    logic [IS_W-1:0]           ecfg_lie;
    logic [1:0]                is_soft;
    logic                      soft_d;
    ecode_e                    ecode;
    logic [8:0]                esub;
    logic [CSR_W-1:EENTRY_VA_LO] eentry_va;
    logic                      pg_next;
    logic                      da_next;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            exc_d  <= 1'b0;
            soft_d <= 1'b0;
        end else begin
            exc_d  <= exception;
            soft_d <= |is_soft;
        end
    end

    // Entry acts once per exception, on its rising edge
    assign exc_pulse = exception && !exc_d;

    assign pg_next = wr_data[CRMD_PG];
    assign da_next = wr_data[CRMD_DA];

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd_plv  <= 2'd0;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= 2'd1;
            crmd_datm <= 2'd1;
        end else if (ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
            // Leaving a TLB refill handler turns paging back on
            if (ecode == ECODE_TLBR) begin
                crmd_da <= 1'b0;
                crmd_pg <= 1'b1;
            end
        end else if (exc_pulse) begin
            crmd_plv <= 2'd0;
            crmd_ie  <= 1'b0;
            if (tlb_exception) begin
                crmd_da <= 1'b1;
                crmd_pg <= 1'b0;
            end
        end else if (wr_en && wr_addr == CSR_CRMD) begin
            crmd_plv  <= wr_data[CRMD_PLV_LO +: 2];
            crmd_ie   <= wr_data[CRMD_IE];
            crmd_datf <= wr_data[CRMD_DATF_LO +: 2];
            crmd_datm <= wr_data[CRMD_DATM_LO +: 2];
            if (pg_next ^ da_next) begin
                crmd_pg <= pg_next;
                crmd_da <= da_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            prmd_pplv <= 2'd0;
            prmd_pie  <= 1'b0;
            ecfg_lie  <= '0;
            is_soft   <= 2'd0;
            ecode     <= ECODE_INT;
            esub      <= 9'd0;
        end else begin
            if (exc_pulse) begin
                prmd_pplv <= crmd_plv;
                prmd_pie  <= crmd_ie;
            end else if (wr_en && wr_addr == CSR_PRMD) begin
                prmd_pplv <= wr_data[1:0];
                prmd_pie  <= wr_data[2];
            end
            if (wr_en && wr_addr == CSR_ECFG) begin
                ecfg_lie <= wr_data[IS_W-1:0] & LIE_MASK;
            end
            if (wen_expcode || exc_pulse) begin
                ecode <= ecode_e'(expcode_in[5:0]);
                esub  <= (expcode_in[5:0] == ECODE_INT) ? 9'd0 : {8'd0, expcode_in[6]};
            end else if (wr_en && wr_addr == CSR_ESTAT) begin
                is_soft <= wr_data[ESTAT_IS_SOFT_LO +: 2];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wen_era) begin
            // Step past the instruction when a soft interrupt was pending
            era <= era_in + (soft_d ? 32'd4 : 32'd0);
        end else if (wr_en && wr_addr == CSR_ERA) begin
            era <= wr_data;
        end
        if (wen_badv) begin
            badv <= badv_in;
        end else if (wr_en && wr_addr == CSR_BADV) begin
            badv <= wr_data;
        end
        if (wr_en && wr_addr == CSR_EENTRY) begin
            eentry_va <= wr_data[CSR_W-1:EENTRY_VA_LO];
        end
    end

    always_comb begin
        crmd = '0;
        crmd[CRMD_PLV_LO +: 2]  = crmd_plv;
        crmd[CRMD_IE]           = crmd_ie;
        crmd[CRMD_DA]           = crmd_da;
        crmd[CRMD_PG]           = crmd_pg;
        crmd[CRMD_DATF_LO +: 2] = crmd_datf;
        crmd[CRMD_DATM_LO +: 2] = crmd_datm;
        estat = '0;
        estat[ESTAT_IS_SOFT_LO +: 2] = is_soft;
        estat[ESTAT_IS_HARD_LO +: 8] = hardware_interrupt;
        estat[ESTAT_IS_TI]           = ti_pending;
        estat[ESTAT_ECODE_LO +: 6]   = ecode;
        estat[ESTAT_ESUB_LO +: 9]    = esub;
    end

    assign prmd   = {29'd0, prmd_pie, prmd_pplv};
    assign ecfg   = {{(CSR_W - IS_W){1'b0}}, ecfg_lie};
    assign eentry = {eentry_va, {EENTRY_VA_LO{1'b0}}};

    assign cpu_interrupt = crmd_ie && |(ecfg_lie & estat[IS_W-1:0]);
    // Any status bit ends idle, enabled or not
    assign idle_over     = |estat[IS_W-1:0];

endmodule

// File: csr_timer.sv
module csr_timer import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  aresetn,
    input  logic                  wr_en,
    input  logic [CSR_ADDR_W-1:0] wr_addr,
    input  logic [CSR_W-1:0]      wr_data,
    output logic [CSR_W-1:0]      tcfg,
    output logic [CSR_W-1:0]      tval,
    output logic                  ti_pending
);

    logic                                tcfg_en;
    logic                                tcfg_periodic;
    logic [CSR_W-1:TCFG_INITVAL_LO]      tcfg_initval;
    logic                                set_timer;
    logic                                time_out;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
            set_timer     <= 1'b0;
        end else begin
            set_timer <= wr_en && wr_addr == CSR_TCFG;
            if (wr_en && wr_addr == CSR_TCFG) begin
                tcfg_en       <= wr_data[TCFG_EN];
                tcfg_periodic <= wr_data[TCFG_PERIODIC];
                tcfg_initval  <= wr_data[CSR_W-1:TCFG_INITVAL_LO];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval     <= '0;
            time_out <= 1'b0;
        end else if (tval == '0 || set_timer) begin
            time_out <= 1'b0;
            if (tcfg_periodic || set_timer) begin
                tval <= {{TCFG_INITVAL_LO{1'b0}}, tcfg_initval} + CSR_W'(TIMER_BIAS);
            end
        end else if (tcfg_en) begin
            tval     <= tval - 1'b1;
            time_out <= (tval == CSR_W'(1));
        end
    end

    // Clear wins over a timeout on the same edge
    always_ff @(posedge clk) begin
        if (!aresetn || (wr_en && wr_addr == CSR_TICLR)) begin
            ti_pending <= 1'b0;
        end else if (time_out) begin
            ti_pending <= 1'b1;
        end
    end

    assign tcfg = {tcfg_initval, tcfg_periodic, tcfg_en};

endmodule

// File: csr_save_llbit.sv
module csr_save_llbit import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  aresetn,
    input  logic                  wr_en,
    input  logic [CSR_ADDR_W-1:0] wr_addr,
    input  logic [CSR_W-1:0]      wr_data,
    input  logic                  ertn,
    input  logic                  llbit_set,
    input  logic                  llbit_clear,
    output logic [CSR_W-1:0]      save0,
    output logic [CSR_W-1:0]      save1,
    output logic [CSR_W-1:0]      save2,
    output logic [CSR_W-1:0]      save3,
    output logic [CSR_W-1:0]      llbctl,
    output logic [CSR_W-1:0]      tid,
    output logic                  llbit
);

    logic [CSR_W-1:0] save [4];
    logic             rollb;
    logic             klo;

    // SAVE0 to SAVE3 sit on consecutive addresses
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_en && wr_addr == CSR_ADDR_W'(CSR_SAVE0 + i)) begin
                save[i] <= wr_data;
            end
        end
        if (wr_en && wr_addr == CSR_TID) begin
            tid <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            rollb <= 1'b1;
            klo   <= 1'b0;
        end else if (llbit_set) begin
            rollb <= 1'b1;
        end else if (ertn) begin
            rollb <= klo;
            klo   <= 1'b0;
        end else if (llbit_clear) begin
            rollb <= 1'b0;
        end else if (wr_en && wr_addr == CSR_LLBCTL) begin
            if (wr_data[LLBCTL_WCLLB]) begin
                rollb <= 1'b0;
            end
            klo <= wr_data[LLBCTL_KLO];
        end
    end

    always_comb begin
        llbctl = '0;
        llbctl[LLBCTL_ROLLB] = rollb;
        llbctl[LLBCTL_KLO]   = klo;
    end

    assign save0 = save[0];
    assign save1 = save[1];
    assign save2 = save[2];
    assign save3 = save[3];
    // A set in flight already counts
    assign llbit = rollb || llbit_set;

endmodule

// File: csr_read_mux.sv
module csr_read_mux import csr_pkg::*; (
    input  logic [CSR_ADDR_W-1:0] addr_in,
    input  logic [CSR_W-1:0]      crmd,
    input  logic [CSR_W-1:0]      prmd,
    input  logic [CSR_W-1:0]      ecfg,
    input  logic [CSR_W-1:0]      estat,
    input  logic [CSR_W-1:0]      era,
    input  logic [CSR_W-1:0]      badv,
    input  logic [CSR_W-1:0]      eentry,
    input  logic [CSR_W-1:0]      save0,
    input  logic [CSR_W-1:0]      save1,
    input  logic [CSR_W-1:0]      save2,
    input  logic [CSR_W-1:0]      save3,
    input  logic [CSR_W-1:0]      llbctl,
    input  logic [CSR_W-1:0]      tid,
    input  logic [CSR_W-1:0]      tcfg,
    input  logic [CSR_W-1:0]      tval,
    output logic [CSR_W-1:0]      rdata
);

    always_comb begin
        case (addr_in)
            CSR_CRMD:   rdata = crmd;
            CSR_PRMD:   rdata = prmd;
            CSR_ECFG:   rdata = ecfg & {{(CSR_W - IS_W){1'b0}}, LIE_MASK};
            CSR_ESTAT:  rdata = estat;
            CSR_ERA:    rdata = era;
            CSR_BADV:   rdata = badv;
            CSR_EENTRY: rdata = eentry;
            CSR_SAVE0:  rdata = save0;
            CSR_SAVE1:  rdata = save1;
            CSR_SAVE2:  rdata = save2;
            CSR_SAVE3:  rdata = save3;
            CSR_LLBCTL: rdata = llbctl;
            CSR_TID:    rdata = tid;
            CSR_TCFG:   rdata = tcfg;
            CSR_TVAL:   rdata = tval;
            // Write-only clear
            CSR_TICLR:  rdata = '0;
            default:    rdata = '0;
        endcase
    end

endmodule

// File: csr_top.sv
module csr_top import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  aresetn,
    input  logic                  d_idle,
    input  logic                  wen_in,
    input  logic [CSR_ADDR_W-1:0] addr_in,
    input  logic [CSR_W-1:0]      wdata_in,
    input  logic                  flush_to_priv_wr_csr,
    input  logic                  exception,
    input  logic                  ertn,
    input  logic                  tlb_exception,
    input  logic [6:0]            expcode_in,
    input  logic                  wen_expcode,
    input  logic [CSR_W-1:0]      era_in,
    input  logic                  wen_era,
    input  logic [CSR_W-1:0]      badv_in,
    input  logic                  wen_badv,
    input  logic                  llbit_set,
    input  logic                  llbit_clear,
    input  logic [7:0]            hardware_interrupt,
    output logic [CSR_W-1:0]      rdata,
    output logic [CSR_W-1:0]      crmd,
    output logic [CSR_W-1:0]      estat,
    output logic [CSR_W-1:0]      era_out,
    output logic [CSR_W-1:0]      eentry,
    output logic [CSR_W-1:0]      tid,
    output logic                  cpu_interrupt,
    output logic                  idle_over,
    output logic                  llbit,
    output logic                  wen_csr
);

    logic                  wr_en;
    logic [CSR_ADDR_W-1:0] wr_addr;
    logic [CSR_W-1:0]      wr_data;
    logic                  ti_pending;
    logic [CSR_W-1:0]      prmd;
    logic [CSR_W-1:0]      ecfg;
    logic [CSR_W-1:0]      badv;
    logic [CSR_W-1:0]      save0;
    logic [CSR_W-1:0]      save1;
    logic [CSR_W-1:0]      save2;
    logic [CSR_W-1:0]      save3;
    logic [CSR_W-1:0]      llbctl;
    logic [CSR_W-1:0]      tcfg;
    logic [CSR_W-1:0]      tval;

    csr_write_stage u_write_stage (
        .clk(clk), .aresetn(aresetn), .d_idle(d_idle), .wen_in(wen_in),
        .addr_in(addr_in), .wdata_in(wdata_in),
        .flush_to_priv_wr_csr(flush_to_priv_wr_csr),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .wen_csr(wen_csr)
    );

    csr_trap_regs u_trap_regs (
        .clk(clk), .aresetn(aresetn),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .exception(exception), .ertn(ertn), .tlb_exception(tlb_exception),
        .expcode_in(expcode_in), .wen_expcode(wen_expcode),
        .era_in(era_in), .wen_era(wen_era), .badv_in(badv_in), .wen_badv(wen_badv),
        .hardware_interrupt(hardware_interrupt), .ti_pending(ti_pending),
        .crmd(crmd), .prmd(prmd), .ecfg(ecfg), .estat(estat), .era(era_out),
        .badv(badv), .eentry(eentry),
        .cpu_interrupt(cpu_interrupt), .idle_over(idle_over)
    );

    csr_timer u_timer (
        .clk(clk), .aresetn(aresetn),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .tcfg(tcfg), .tval(tval), .ti_pending(ti_pending)
    );

    csr_save_llbit u_save_llbit (
        .clk(clk), .aresetn(aresetn),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .ertn(ertn), .llbit_set(llbit_set), .llbit_clear(llbit_clear),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3),
        .llbctl(llbctl), .tid(tid), .llbit(llbit)
    );

    csr_read_mux u_read_mux (
        .addr_in(addr_in),
        .crmd(crmd), .prmd(prmd), .ecfg(ecfg), .estat(estat),
        .era(era_out), .badv(badv), .eentry(eentry),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3),
        .llbctl(llbctl), .tid(tid), .tcfg(tcfg), .tval(tval),
        .rdata(rdata)
    );

endmodule

// File: csr_properties.sv
module csr_properties import csr_pkg::*; (
    input logic             clk,
    input logic             aresetn,
    input logic             exception,
    input logic             ertn,
    input logic [6:0]       expcode_in,
    input logic [7:0]       hardware_interrupt,
    input logic             llbit_set,
    input logic             llbit_clear,
    input logic [CSR_W-1:0] crmd,
    input logic [CSR_W-1:0] estat,
    input logic             cpu_interrupt,
    input logic             idle_over,
    input logic             llbit
);

    int unsigned fail_count = 0;

    // Direct and paged translation are never on together
    a_pg_da: assert property (@(posedge clk) disable iff (!aresetn)
        crmd[CRMD_PG] != crmd[CRMD_DA])
    else begin
        $error("crmd PG and DA are equal");
        fail_count++;
    end

    a_exc_entry: assert property (@(posedge clk) disable iff (!aresetn)
        $rose(exception) && !ertn |=> (crmd[2:0] == 3'd0) &&
        (estat[ESTAT_ECODE_LO +: 6] == $past(expcode_in[5:0])))
    else begin
        $error("exception entry did not clear PLV and IE or load the code");
        fail_count++;
    end

    // Return from refill goes back to paging
    a_ertn_tlbr: assert property (@(posedge clk) disable iff (!aresetn)
        ertn && (estat[ESTAT_ECODE_LO +: 6] == ECODE_TLBR) |=>
        crmd[CRMD_PG] && !crmd[CRMD_DA])
    else begin
        $error("return from TLB refill did not select paged mode");
        fail_count++;
    end

    a_hw_int: assert property (@(posedge clk) disable iff (!aresetn)
        estat[ESTAT_IS_HARD_LO +: 8] == hardware_interrupt)
    else begin
        $error("estat hardware interrupt bits differ from the input lines");
        fail_count++;
    end

    a_idle_over: assert property (@(posedge clk) disable iff (!aresetn)
        idle_over == |estat[IS_W-1:0])
    else begin
        $error("idle_over differs from the OR of the status bits");
        fail_count++;
    end

    a_cpu_int: assert property (@(posedge clk) disable iff (!aresetn)
        cpu_interrupt |-> crmd[CRMD_IE])
    else begin
        $error("cpu_interrupt high while crmd IE is clear");
        fail_count++;
    end

    a_llbit_set: assert property (@(posedge clk) disable iff (!aresetn)
        llbit_set |-> llbit)
    else begin
        $error("llbit low while llbit_set is high");
        fail_count++;
    end

    a_llbit_clear: assert property (@(posedge clk) disable iff (!aresetn)
        llbit_clear && !llbit_set && !ertn |=> llbit == llbit_set)
    else begin
        $error("llbit still high after llbit_clear");
        fail_count++;
    end

endmodule

bind csr_top csr_properties u_props (
    .clk(clk),
    .aresetn(aresetn),
    .exception(exception),
    .ertn(ertn),
    .expcode_in(expcode_in),
    .hardware_interrupt(hardware_interrupt),
    .llbit_set(llbit_set),
    .llbit_clear(llbit_clear),
    .crmd(crmd),
    .estat(estat),
    .cpu_interrupt(cpu_interrupt),
    .idle_over(idle_over),
    .llbit(llbit)
);

// File: tb_csr_top.sv
module tb_csr_top import csr_pkg::*; ();

    localparam int TIMER_INIT      = 20;
    localparam int TIMER_BOUND     = TIMER_INIT + TIMER_BIAS + 6;
    localparam int TEST_CYCLES     = 300 + TIMER_BOUND;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 4;

    logic                  clk;
    logic                  aresetn;
    logic                  d_idle;
    logic                  wen_in;
    logic [CSR_ADDR_W-1:0] addr_in;
    logic [CSR_W-1:0]      wdata_in;
    logic                  flush_to_priv_wr_csr;
    logic                  exception;
    logic                  ertn;
    logic                  tlb_exception;
    logic [6:0]            expcode_in;
    logic                  wen_expcode;
    logic [CSR_W-1:0]      era_in;
    logic                  wen_era;
    logic [CSR_W-1:0]      badv_in;
    logic                  wen_badv;
    logic                  llbit_set;
    logic                  llbit_clear;
    logic [7:0]            hardware_interrupt;
    logic [CSR_W-1:0]      rdata;
    logic [CSR_W-1:0]      crmd;
    logic [CSR_W-1:0]      estat;
    logic [CSR_W-1:0]      era_out;
    logic [CSR_W-1:0]      eentry;
    logic [CSR_W-1:0]      tid;
    logic                  cpu_interrupt;
    logic                  idle_over;
    logic                  llbit;
    logic                  wen_csr;

    integer           seed;
    int               errors;
    int               tests_run;
    int               tests_failed;
    int               fails_at_start;
    int               waited;
    int               ie_val;
    logic [CSR_W-1:0] value;
    logic [CSR_W-1:0] rd_val;
    logic [2:0]       crmd_before;
    logic             rollb_model;
    logic             set_bit;
    logic             clear_bit;

    csr_top u_csr_top (
        .clk(clk), .aresetn(aresetn), .d_idle(d_idle), .wen_in(wen_in),
        .addr_in(addr_in), .wdata_in(wdata_in),
        .flush_to_priv_wr_csr(flush_to_priv_wr_csr),
        .exception(exception), .ertn(ertn), .tlb_exception(tlb_exception),
        .expcode_in(expcode_in), .wen_expcode(wen_expcode),
        .era_in(era_in), .wen_era(wen_era), .badv_in(badv_in), .wen_badv(wen_badv),
        .llbit_set(llbit_set), .llbit_clear(llbit_clear),
        .hardware_interrupt(hardware_interrupt),
        .rdata(rdata), .crmd(crmd), .estat(estat), .era_out(era_out),
        .eentry(eentry), .tid(tid), .cpu_interrupt(cpu_interrupt),
        .idle_over(idle_over), .llbit(llbit), .wen_csr(wen_csr)
    );

    always #20 clk = ~clk;

    function automatic int fail_total();
        return errors + int'(u_csr_top.u_props.fail_count);
    endfunction

    task automatic check_value(input string name, input logic [CSR_W-1:0] got,
                               input logic [CSR_W-1:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s = %08h, expected %08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic begin_test();
        fails_at_start = fail_total();
    endtask

    task automatic report_test(input int num, input string name);
        int fails;
        fails = fail_total() - fails_at_start;
        tests_run++;
        if (fails == 0) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d failures", num, name, fails);
        end
    endtask

    task automatic write_csr(input logic [CSR_ADDR_W-1:0] addr, input logic [CSR_W-1:0] data);
        int wait_cnt;
        @(negedge clk);
        addr_in  = addr;
        wdata_in = data;
        wen_in   = 1'b1;
        @(negedge clk);
        wen_in   = 1'b0;
        wait_cnt = 0;
        while (!wen_csr && wait_cnt < 8) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!wen_csr) begin
            $display("Write to CSR %03h was never taken by the write stager", addr);
            errors++;
        end
        // Commit lands on the third idle edge
        repeat (WRITE_IDLE_CYCLES) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic read_csr(input logic [CSR_ADDR_W-1:0] addr, output logic [CSR_W-1:0] data);
        @(negedge clk);
        addr_in = addr;
        @(negedge clk);
        data = rdata;
    endtask

    // Gap cycles with the core busy between capture and commit
    task automatic staged_write_check(input logic [CSR_ADDR_W-1:0] addr, input string name,
                                      input int gap);
        logic [CSR_W-1:0] old_val;
        int               i;
        old_val = $random(seed);
        write_csr(addr, old_val);
        @(negedge clk);
        wdata_in = ~old_val;
        wen_in   = 1'b1;
        @(negedge clk);
        wen_in = 1'b0;
        for (i = 0; i < gap + WRITE_IDLE_CYCLES; i++) begin
            check_value(name, rdata, old_val);
            if (gap > 0 && i == 0) begin
                d_idle = 1'b0;
            end
            if (gap > 0 && i == gap) begin
                d_idle = 1'b1;
            end
            @(negedge clk);
        end
        check_value(name, rdata, ~old_val);
    endtask

    task automatic flush_check(input logic [CSR_ADDR_W-1:0] addr, input string name);
        logic [CSR_W-1:0] old_val;
        old_val = $random(seed);
        write_csr(addr, old_val);
        @(negedge clk);
        wdata_in = ~old_val;
        wen_in   = 1'b1;
        @(negedge clk);
        wen_in               = 1'b0;
        flush_to_priv_wr_csr = 1'b1;
        @(negedge clk);
        flush_to_priv_wr_csr = 1'b0;
        repeat (WRITE_IDLE_CYCLES + 2) @(negedge clk);
        check_value(name, rdata, old_val);
    endtask

    task automatic write_crmd_expect_mode(input logic [CSR_W-1:0] data, input logic [1:0] mode);
        write_csr(CSR_CRMD, data);
        check_value("crmd.pg_da", {30'd0, crmd[CRMD_PG], crmd[CRMD_DA]}, {30'd0, mode});
    endtask

    task automatic raise_exception(input logic [5:0] code, input logic tlb);
        @(negedge clk);
        exception     = 1'b1;
        expcode_in    = {1'b0, code};
        tlb_exception = tlb;
        @(negedge clk);
        exception     = 1'b0;
        tlb_exception = 1'b0;
        check_value("crmd.plv_ie", crmd[2:0], 3'd0);
        check_value("estat.ecode", estat[ESTAT_ECODE_LO +: 6], code);
    endtask

    task automatic pulse_ertn();
        @(negedge clk);
        ertn = 1'b1;
        @(negedge clk);
        ertn = 1'b0;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        seed                 = 32'hfe16_74aa;
        clk                  = 1'b0;
        aresetn              = 1'b0;
        d_idle               = 1'b1;
        wen_in               = 1'b0;
        addr_in              = '0;
        wdata_in             = '0;
        flush_to_priv_wr_csr = 1'b0;
        exception            = 1'b0;
        ertn                 = 1'b0;
        tlb_exception        = 1'b0;
        expcode_in           = '0;
        wen_expcode          = 1'b0;
        era_in               = '0;
        wen_era              = 1'b0;
        badv_in              = '0;
        wen_badv             = 1'b0;
        llbit_set            = 1'b0;
        llbit_clear          = 1'b0;
        hardware_interrupt   = '0;
        errors               = 0;
        tests_run            = 0;
        tests_failed         = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        aresetn = 1'b1;

        begin_test();
        staged_write_check(CSR_SAVE0, "save0", 0);
        staged_write_check(CSR_SAVE1, "save1", 4);
        flush_check(CSR_SAVE2, "save2");
        value = $random(seed);
        write_csr(CSR_SAVE3, value);
        read_csr(CSR_SAVE3, rd_val);
        check_value("save3", rd_val, value);
        value = $random(seed);
        write_csr(CSR_TID, value);
        check_value("tid", tid, value);
        // Entry address keeps only the bits above the low six
        value = $random(seed);
        write_csr(CSR_EENTRY, value);
        check_value("eentry", eentry, value & ~32'h0000_003f);
        value = $random(seed);
        write_csr(CSR_ERA, value);
        check_value("era_out", era_out, value);
        report_test(1, "staged write");

        begin_test();
        write_crmd_expect_mode(32'h0000_00b8, 2'b01);
        write_crmd_expect_mode(32'h0000_00a0, 2'b01);
        write_crmd_expect_mode(32'h0000_00b0, 2'b10);
        write_crmd_expect_mode(32'h0000_00a8, 2'b01);
        report_test(2, "translation mode");

        begin_test();
        value = 32'h0000_00af;
        write_csr(CSR_CRMD, value);
        crmd_before = value[2:0];
        raise_exception(ECODE_SYS, 1'b0);
        pulse_ertn();
        check_value("crmd.plv_ie", crmd[2:0], crmd_before);
        // Paged mode first, so the refill entry has to switch it
        write_csr(CSR_CRMD, 32'h0000_00b7);
        raise_exception(ECODE_TLBR, 1'b1);
        check_value("crmd.pg_da", {30'd0, crmd[CRMD_PG], crmd[CRMD_DA]}, 32'h1);
        pulse_ertn();
        check_value("crmd.pg_da", {30'd0, crmd[CRMD_PG], crmd[CRMD_DA]}, 32'h2);
        report_test(3, "exception entry and return");

        begin_test();
        write_csr(CSR_ECFG, 32'h0000_1fff);
        read_csr(CSR_ECFG, value);
        check_value("ecfg", value, 32'h0000_1bff);
        // Same interrupt lines with IE clear, then set
        for (ie_val = 0; ie_val < 2; ie_val++) begin
            write_csr(CSR_CRMD, 32'h0000_00a8 | (32'(ie_val) << CRMD_IE));
            repeat (16) begin
                hardware_interrupt = $random(seed);
                @(negedge clk);
                check_value("estat.is_hard", estat[ESTAT_IS_HARD_LO +: 8], hardware_interrupt);
                check_value("idle_over", idle_over, |hardware_interrupt);
                check_value("cpu_interrupt", cpu_interrupt,
                            (ie_val == 1) && (hardware_interrupt != 8'd0));
            end
        end
        hardware_interrupt = '0;
        report_test(4, "interrupt status");

        begin_test();
        write_csr(CSR_TCFG, 32'(TIMER_INIT << TCFG_INITVAL_LO) | 32'h1);
        waited = 0;
        while (!estat[ESTAT_IS_TI] && waited < TIMER_BOUND) begin
            @(negedge clk);
            waited++;
        end
        if (!estat[ESTAT_IS_TI]) begin
            $display("Timer interrupt did not rise within %0d cycles of the TCFG write",
                     TIMER_BOUND);
            errors++;
        end
        write_csr(CSR_TICLR, 32'h1);
        check_value("estat.ti", estat[ESTAT_IS_TI], 1'b0);
        report_test(5, "timer");

        begin_test();
        @(negedge clk);
        llbit_set = 1'b1;
        @(negedge clk);
        llbit_set   = 1'b0;
        llbit_clear = 1'b1;
        @(negedge clk);
        check_value("llbit", llbit, 1'b0);
        rollb_model = 1'b0;
        repeat (24) begin
            set_bit     = $random(seed);
            clear_bit   = $random(seed);
            llbit_set   = set_bit;
            llbit_clear = clear_bit;
            @(negedge clk);
            if (set_bit) begin
                rollb_model = 1'b1;
            end else if (clear_bit) begin
                rollb_model = 1'b0;
            end
            check_value("llbit", llbit, rollb_model);
        end
        llbit_set   = 1'b0;
        llbit_clear = 1'b0;
        report_test(6, "load-linked bit");

        repeat (2) @(negedge clk);
        $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, u_csr_top.u_props.fail_count);
        if (tests_failed == 0 && fail_total() == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: list.f
csr_pkg.sv
csr_write_stage.sv
csr_trap_regs.sv
csr_timer.sv
csr_save_llbit.sv
csr_read_mux.sv
csr_top.sv
csr_properties.sv
tb_csr_top.sv
